// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // --------------------------------------------------
    // Core widths
    // --------------------------------------------------
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int inst_w     = 32;
    localparam int pc_w       = 64;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [inst_w-1:0] ebreak_word = 32'h0010_0073;

    // funct3 values shared by the I and R forms
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // Decoded micro-op, decode to execute
    typedef struct packed {
        logic [pc_w-1:0]       pc;
        logic [inst_w-1:0]     inst;
        alu_op_t               alu_op;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  use_imm;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic                  halt;
        logic                  illegal;
    } uop_t;

    // Execute result, execute to result stage
    typedef struct packed {
        logic [pc_w-1:0]       pc;
        logic [inst_w-1:0]     inst;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic [xlen-1:0]       result;
        logic                  halt;
        logic                  illegal;
    } exec_t;

endpackage

// File: rtl/trace_pkg.sv
package trace_pkg;

    localparam int seq_w = 64;

    // One retired instruction as seen by the tracer
    typedef struct packed {
        logic [cpu_pkg::pc_w-1:0]       pc;
        logic [cpu_pkg::inst_w-1:0]     inst;
        logic                           rd_we;
        logic [cpu_pkg::reg_addr_w-1:0] rd;
        logic [cpu_pkg::xlen-1:0]       rd_data;
        logic                           halt;
        logic                           illegal;
    } retire_t;

    // Numbered commit record, seq counts from 0 after reset
    typedef struct packed {
        logic [seq_w-1:0] seq;
        retire_t          ret;
    } commit_rec_t;

endpackage

// File: rtl/inst_decode.sv
module inst_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic [cpu_pkg::pc_w-1:0]   in_pc,
    input  logic [cpu_pkg::inst_w-1:0] in_inst,
    output logic                       uop_valid,
    output cpu_pkg::uop_t              uop
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [cpu_pkg::xlen-1:0] imm_i;
    logic [cpu_pkg::xlen-1:0] imm_u;
    logic                     legal;
    logic                     writes;
    logic                     accept;
    logic                     stopped;
    cpu_pkg::uop_t            dec;

    assign opcode = in_inst[6:0];
    assign funct3 = in_inst[14:12];
    assign funct7 = in_inst[31:25];

    assign imm_i = {{(cpu_pkg::xlen-12){in_inst[31]}}, in_inst[31:20]};
    assign imm_u = {{(cpu_pkg::xlen-32){in_inst[31]}}, in_inst[31:12], 12'b0};

    // Nothing enters once EBREAK has been taken
    assign accept = in_valid && !stopped;

    // --------------------------------------------------
    // Field decode
    // --------------------------------------------------
    always_comb begin
        legal       = 1'b0;
        writes      = 1'b0;
        dec         = '0;
        dec.pc      = in_pc;
        dec.inst    = in_inst;
        dec.alu_op  = cpu_pkg::alu_add;
        dec.rs1     = in_inst[19:15];
        dec.rs2     = in_inst[24:20];
        dec.rd      = in_inst[11:7];
        dec.imm     = imm_i;
        case (opcode)
            cpu_pkg::op_imm: begin
                dec.use_imm = 1'b1;
                legal       = 1'b1;
                writes      = 1'b1;
                case (funct3)
                    cpu_pkg::f3_add: dec.alu_op = cpu_pkg::alu_add;
                    cpu_pkg::f3_xor: dec.alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::f3_or:  dec.alu_op = cpu_pkg::alu_or;
                    cpu_pkg::f3_and: dec.alu_op = cpu_pkg::alu_and;
                    default:         legal = 1'b0;
                endcase
            end
            cpu_pkg::op_reg: begin
                legal  = 1'b1;
                writes = 1'b1;
                if (funct7 == cpu_pkg::f7_sub && funct3 == cpu_pkg::f3_add) begin
                    dec.alu_op = cpu_pkg::alu_sub;
                end else if (funct7 != cpu_pkg::f7_base) begin
                    legal = 1'b0;
                end else begin
                    case (funct3)
                        cpu_pkg::f3_add: dec.alu_op = cpu_pkg::alu_add;
                        cpu_pkg::f3_xor: dec.alu_op = cpu_pkg::alu_xor;
                        cpu_pkg::f3_or:  dec.alu_op = cpu_pkg::alu_or;
                        cpu_pkg::f3_and: dec.alu_op = cpu_pkg::alu_and;
                        default:         legal = 1'b0;
                    endcase
                end
            end
            cpu_pkg::op_lui: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = cpu_pkg::alu_pass_b;
                legal       = 1'b1;
                writes      = 1'b1;
            end
            cpu_pkg::op_system: begin
                // Only the exact EBREAK word is accepted
                if (in_inst == cpu_pkg::ebreak_word) begin
                    legal    = 1'b1;
                    dec.halt = 1'b1;
                end
            end
            default: ;
        endcase
        dec.we      = legal && writes && (dec.rd != '0);
        dec.illegal = !legal;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            uop_valid <= 1'b0;
            stopped   <= 1'b0;
        end else begin
            uop_valid <= accept;
            if (accept && dec.halt) begin
                stopped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop <= dec;
        end
    end

    // EBREAK itself leaves in the cycle stopped rises, nothing follows it
    a_no_issue_after_stop: assert property (
        @(posedge clk) disable iff (reset) stopped |=> !uop_valid
    );

endmodule

// File: rtl/alu_execute.sv
module alu_execute (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           uop_valid,
    input  cpu_pkg::uop_t                  uop,
    output logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [cpu_pkg::xlen-1:0]       rs1_data,
    input  logic [cpu_pkg::xlen-1:0]       rs2_data,
    input  logic                           wb_valid,
    input  cpu_pkg::exec_t                 wb_bypass,
    output logic                           ex_valid,
    output cpu_pkg::exec_t                 ex
);

    logic                     byp1;
    logic                     byp2;
    logic [cpu_pkg::xlen-1:0] op_a;
    logic [cpu_pkg::xlen-1:0] op_b_reg;
    logic [cpu_pkg::xlen-1:0] op_b;
    logic [cpu_pkg::xlen-1:0] alu_out;

    assign rs1_addr = uop.rs1;
    assign rs2_addr = uop.rs2;

    // --------------------------------------------------
    // Operand select
    // --------------------------------------------------
    // Previous instruction is still on the write port this cycle
    assign byp1 = wb_valid && (wb_bypass.rd == uop.rs1) && (uop.rs1 != '0);
    assign byp2 = wb_valid && (wb_bypass.rd == uop.rs2) && (uop.rs2 != '0);

    assign op_a     = byp1 ? wb_bypass.result : rs1_data;
    assign op_b_reg = byp2 ? wb_bypass.result : rs2_data;
    assign op_b     = uop.use_imm ? uop.imm : op_b_reg;

    always_comb begin
        case (uop.alu_op)
            cpu_pkg::alu_add:    alu_out = op_a + op_b;
            cpu_pkg::alu_sub:    alu_out = op_a - op_b;
            cpu_pkg::alu_xor:    alu_out = op_a ^ op_b;
            cpu_pkg::alu_or:     alu_out = op_a | op_b;
            cpu_pkg::alu_and:    alu_out = op_a & op_b;
            cpu_pkg::alu_pass_b: alu_out = op_b;
            default:             alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= uop_valid;
        end
    end

    // Non-writing instructions carry a zero result
    always_ff @(posedge clk) begin
        if (uop_valid) begin
            ex.pc      <= uop.pc;
            ex.inst    <= uop.inst;
            ex.rd      <= uop.rd;
            ex.we      <= uop.we;
            ex.result  <= uop.we ? alu_out : '0;
            ex.halt    <= uop.halt;
            ex.illegal <= uop.illegal;
        end
    end

    // Decode never enables a write to x0, so x0 is never forwarded
    a_no_x0_bypass: assert property (
        @(posedge clk) disable iff (reset) wb_valid |-> (wb_bypass.rd != '0)
    );

endmodule

// File: rtl/writeback_regfile.sv
module writeback_regfile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ex_valid,
    input  cpu_pkg::exec_t                 ex,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [cpu_pkg::xlen-1:0]       rs1_data,
    output logic [cpu_pkg::xlen-1:0]       rs2_data,
    output logic                           wb_valid,
    output cpu_pkg::exec_t                 wb,
    output logic                           retire_valid,
    output trace_pkg::retire_t             retire
);

    logic [cpu_pkg::xlen-1:0] regs [2**cpu_pkg::reg_addr_w];

    // Write port, also the forwarding source for execute
    assign wb_valid = ex_valid && ex.we;
    assign wb       = ex;

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // --------------------------------------------------
    // Register file
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[ex.rd] <= ex.result;
        end
    end

    // Retirement register
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire.pc      <= ex.pc;
            retire.inst    <= ex.inst;
            retire.rd_we   <= ex.we;
            retire.rd      <= ex.rd;
            retire.rd_data <= ex.result;
            retire.halt    <= ex.halt;
            retire.illegal <= ex.illegal;
        end
    end

    a_x0_zero: assert property (
        @(posedge clk) disable iff (reset) regs[0] == '0
    );

endmodule

// File: rtl/commit_trace.sv
module commit_trace (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  retire_valid,
    input  trace_pkg::retire_t    retire,
    output logic                  commit_valid,
    output trace_pkg::commit_rec_t commit,
    output logic                  halted
);

    logic [trace_pkg::seq_w-1:0] seq;

    // --------------------------------------------------
    // Numbering and halt tracking
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            seq          <= '0;
            halted       <= 1'b0;
        end else begin
            commit_valid <= retire_valid;
            if (retire_valid) begin
                seq <= seq + 1'b1;
            end
            // Goes high the edge after the halt record is shown
            if (commit_valid && commit.ret.halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire_valid) begin
            commit.seq <= seq;
            commit.ret <= retire;
        end
    end

    // Decode stops issuing at EBREAK, so the pipe must be empty by now
    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (reset) halted |-> !retire_valid
    );

endmodule

// File: rtl/rv64_core_top.sv
module rv64_core_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic [cpu_pkg::pc_w-1:0]   in_pc,
    input  logic [cpu_pkg::inst_w-1:0] in_inst,
    output logic                       commit_valid,
    output trace_pkg::commit_rec_t     commit,
    output logic                       halted
);

    logic                           uop_valid;
    cpu_pkg::uop_t                  uop;
    logic [cpu_pkg::reg_addr_w-1:0] rs1_addr;
    logic [cpu_pkg::reg_addr_w-1:0] rs2_addr;
    logic [cpu_pkg::xlen-1:0]       rs1_data;
    logic [cpu_pkg::xlen-1:0]       rs2_data;
    logic                           wb_valid;
    cpu_pkg::exec_t                 wb;
    logic                           ex_valid;
    cpu_pkg::exec_t                 ex;
    logic                           retire_valid;
    trace_pkg::retire_t             retire;

    inst_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .uop_valid (uop_valid),
        .uop       (uop)
    );

    alu_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .uop_valid (uop_valid),
        .uop       (uop),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_valid  (wb_valid),
        .wb_bypass (wb),
        .ex_valid  (ex_valid),
        .ex        (ex)
    );

    writeback_regfile u_writeback (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex           (ex),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    commit_trace u_trace (
        .clk          (clk),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire       (retire),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halted       (halted)
    );

endmodule

// File: verification/core_tb.sv
module core_tb;

    localparam int clk_period = 20;
    localparam int n_inst     = 240;
    localparam int n_after    = 10;
    localparam int tail       = 20;
    // At most one idle slot before each instruction plus reset, pipe and tail
    localparam int watchdog_time = (2 * (n_inst + 1 + n_after) + 40) * clk_period;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       in_valid;
    logic [cpu_pkg::pc_w-1:0]   in_pc;
    logic [cpu_pkg::inst_w-1:0] in_inst;
    logic                       commit_valid;
    trace_pkg::commit_rec_t     commit;
    logic                       halted;

    logic [15:0]            lfsr_state = 16'd20052;
    logic [63:0]            model_regs [32];
    logic [63:0]            sent = '0;
    trace_pkg::commit_rec_t exp_q [$];
    int                     exp_cycle_q [$];
    trace_pkg::commit_rec_t exp_rec;
    int                     exp_cycle;
    int                     cycle = 0;
    int                     halt_cycle = -1;
    int                     errors = 0;

    rv64_core_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_pc        (in_pc),
        .in_inst      (in_inst),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halted       (halted)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // Random source and encoders
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // Registers limited to x0..x7 so dependencies are frequent
    task automatic make_inst(output logic [31:0] inst);
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] alt;
        take_bits(4, kind);
        take_bits(3, rd);
        take_bits(3, rs1);
        take_bits(3, rs2);
        take_bits(20, imm);
        case (kind)
            1, 11, 15: inst = enc_i(7'b0010011, 3'b000, rd[4:0], rs1[4:0], imm[11:0]);
            2:         inst = enc_i(7'b0010011, 3'b100, rd[4:0], rs1[4:0], imm[11:0]);
            3:         inst = enc_i(7'b0010011, 3'b110, rd[4:0], rs1[4:0], imm[11:0]);
            4:         inst = enc_i(7'b0010011, 3'b111, rd[4:0], rs1[4:0], imm[11:0]);
            5, 12:     inst = enc_r(7'b0000000, 3'b000, rd[4:0], rs1[4:0], rs2[4:0]);
            6, 13:     inst = enc_r(7'b0100000, 3'b000, rd[4:0], rs1[4:0], rs2[4:0]);
            7:         inst = enc_r(7'b0000000, 3'b100, rd[4:0], rs1[4:0], rs2[4:0]);
            8:         inst = enc_r(7'b0000000, 3'b110, rd[4:0], rs1[4:0], rs2[4:0]);
            9:         inst = enc_r(7'b0000000, 3'b111, rd[4:0], rs1[4:0], rs2[4:0]);
            10, 14:    inst = {imm[19:0], rd[4:0], 7'b0110111};
            default: begin
                // Unsupported LD, MUL, SLLI or ECALL encodings
                take_bits(2, alt);
                case (alt[1:0])
                    2'd0:    inst = enc_i(7'b0000011, 3'b011, rd[4:0], rs1[4:0], imm[11:0]);
                    2'd1:    inst = enc_r(7'b0000001, 3'b000, rd[4:0], rs1[4:0], rs2[4:0]);
                    2'd2:    inst = enc_i(7'b0010011, 3'b001, rd[4:0], rs1[4:0],
                                          {6'b000000, imm[5:0]});
                    default: inst = 32'h0000_0073;
                endcase
            end
        endcase
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic trace_pkg::commit_rec_t reference_commit(input logic [63:0] pc,
                                                                input logic [31:0] inst,
                                                                input logic [63:0] seq);
        logic [6:0]             opc;
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic [63:0]            a;
        logic [63:0]            b;
        logic [63:0]            imm_i;
        logic [63:0]            res;
        logic                   legal;
        logic                   writes;
        trace_pkg::commit_rec_t rec;
        opc    = inst[6:0];
        f3     = inst[14:12];
        f7     = inst[31:25];
        a      = model_regs[inst[19:15]];
        b      = model_regs[inst[24:20]];
        imm_i  = {{52{inst[31]}}, inst[31:20]};
        res    = '0;
        legal  = 1'b1;
        writes = 1'b1;
        rec    = '0;
        if (opc == 7'b0010011 && f3 == 3'b000) res = a + imm_i;
        else if (opc == 7'b0010011 && f3 == 3'b100) res = a ^ imm_i;
        else if (opc == 7'b0010011 && f3 == 3'b110) res = a | imm_i;
        else if (opc == 7'b0010011 && f3 == 3'b111) res = a & imm_i;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b000) res = a + b;
        else if (opc == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) res = a - b;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b100) res = a ^ b;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b110) res = a | b;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b111) res = a & b;
        else if (opc == 7'b0110111) res = {{32{inst[31]}}, inst[31:12], 12'b0};
        else if (inst == 32'h0010_0073) begin
            writes       = 1'b0;
            rec.ret.halt = 1'b1;
        end else begin
            legal  = 1'b0;
            writes = 1'b0;
        end
        rec.seq         = seq;
        rec.ret.pc      = pc;
        rec.ret.inst    = inst;
        rec.ret.rd      = inst[11:7];
        rec.ret.rd_we   = legal && writes && (inst[11:7] != 5'd0);
        rec.ret.rd_data = rec.ret.rd_we ? res : 64'd0;
        rec.ret.illegal = !legal;
        if (rec.ret.rd_we) begin
            model_regs[inst[11:7]] = res;
        end
        return rec;
    endfunction

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic drive_slot(input logic valid, input logic [63:0] pc, input logic [31:0] inst);
        in_valid = valid;
        in_pc    = pc;
        in_inst  = inst;
        @(posedge clk);
        #2;
    endtask

    // Expected record is taken in issue order
    task automatic issue(input logic [63:0] pc, input logic [31:0] inst);
        exp_q.push_back(reference_commit(pc, inst, sent));
        exp_cycle_q.push_back(cycle);
        sent = sent + 64'd1;
        drive_slot(1'b1, pc, inst);
    endtask

    initial begin
        logic [31:0] gap;
        logic [31:0] inst;
        logic [63:0] pc;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_pc    = '0;
        in_inst  = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        pc    = 64'h8000_0000;
        for (int n = 0; n < n_inst; n++) begin
            take_bits(2, gap);
            if (gap[1:0] == 2'd0) begin
                drive_slot(1'b0, '0, '0);
            end
            make_inst(inst);
            issue(pc, inst);
            pc = pc + 64'd4;
        end
        issue(pc, 32'h0010_0073);
        pc = pc + 64'd4;
        // Decode must drop all of these
        for (int n = 0; n < n_after; n++) begin
            make_inst(inst);
            drive_slot(1'b1, pc, inst);
            pc = pc + 64'd4;
        end
        in_valid = 1'b0;
        wait (halted);
        repeat (tail) @(posedge clk);
        $display("Errors: %0d, unmatched expected records: %0d", errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // --------------------------------------------------
    // Commit comparison
    // --------------------------------------------------
    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        assert (got == expected) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, expected);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            // halted rises one edge after the halt record
            check_field("halted", 64'(halted), 64'(halt_cycle >= 0 && cycle > halt_cycle));
            if (commit_valid) begin
                assert (halt_cycle < 0 && exp_q.size() > 0) else begin
                    errors++;
                    $display("Unexpected commit pulse at %0t with no instruction pending",
                             $time);
                end
                if (halt_cycle < 0 && exp_q.size() > 0) begin
                    exp_rec   = exp_q.pop_front();
                    exp_cycle = exp_cycle_q.pop_front();
                    check_field("seq", commit.seq, exp_rec.seq);
                    check_field("pc", commit.ret.pc, exp_rec.ret.pc);
                    check_field("inst", 64'(commit.ret.inst), 64'(exp_rec.ret.inst));
                    check_field("rd_we", 64'(commit.ret.rd_we), 64'(exp_rec.ret.rd_we));
                    check_field("rd", 64'(commit.ret.rd), 64'(exp_rec.ret.rd));
                    check_field("rd_data", commit.ret.rd_data, exp_rec.ret.rd_data);
                    check_field("halt", 64'(commit.ret.halt), 64'(exp_rec.ret.halt));
                    check_field("illegal", 64'(commit.ret.illegal), 64'(exp_rec.ret.illegal));
                    check_field("commit cycle", 64'(cycle), 64'(exp_cycle + 4));
                    if (exp_rec.ret.halt) begin
                        halt_cycle = cycle;
                    end
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(watchdog_time);
        $display("Watchdog expired at %0t, commits stopped arriving", $time);
        $display("Errors: %0d, unmatched expected records: %0d", errors, exp_q.size());
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: flist.f
rtl/cpu_pkg.sv
rtl/trace_pkg.sv
rtl/inst_decode.sv
rtl/alu_execute.sv
rtl/writeback_regfile.sv
rtl/commit_trace.sv
rtl/rv64_core_top.sv
verification/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f flist.f \
    && ./obj_dir/Vcore_tb | tee sim.log \
    || echo "Build or simulation step failed"

grep -qx '>>> PASS' sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
